// File: sim.f
+incdir+hdl
hdl/mpu_pkg.sv
hdl/instr_pkg.sv
hdl/ring_buff_ctrl.sv
hdl/info_queue.sv
hdl/thread_mem.sv
hdl/map_man.sv
hdl/dispatch_unit.sv
hdl/mpu_top.sv
bench/tb_clock_gen.sv
bench/tb_mpu.sv

// File: Makefile
# Verilator build and run for the MPU thread memory testbench

VERILATOR ?= verilator
TOP       ?= tb_mpu
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass only when the pass line shows up in the output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/tb_mpu.sv
// MPU subsystem testbench
`timescale 1ns/1ps
`default_nettype none
`include "mpu_defines.svh"

module tb_mpu;

	localparam int NUM_RANDOM  = 12;
	localparam int MAX_RANDOM  = 40;	// Longest random thread
	localparam int WAIT_LIMIT  = 2000;	// Cycles per host word
	localparam int DRAIN_LIMIT = 4000;
	localparam int BIG_A       = 200;
	localparam int BIG_B       = `SIZE_THREAD_MEM - BIG_A + 44;	// Overflows behind BIG_A

	logic                  clock;
	logic                  reset;
	logic                  st_req;
	instr_pkg::instr_t     st_word;
	logic                  st_take;
	logic                  st_wait;
	logic                  out_valid;
	instr_pkg::dispatch_t  out_data;

	instr_pkg::dispatch_t  expect_q [$];	// Reference beats, in arrival order
	logic [31:0]           rng_state;
	int                    mismatches;
	int                    protocol_errors;
	int                    timeouts;

	tb_clock_gen #(
		.PERIOD_NS    (40),
		.RESET_CYCLES (2)
	) u_clock_gen (
		.clock (clock),
		.reset (reset)
	);

	mpu_top i_dut (
		.clock     (clock),
		.reset     (reset),
		.st_req    (st_req),
		.st_word   (st_word),
		.st_take   (st_take),
		.st_wait   (st_wait),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	////////////////////////////////////////////////////////////////////////////
	// Random numbers and reference model
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// One beat per word, last only on the final one
	function automatic void model_thread(input mpu_pkg::id_t id,
		input instr_pkg::instr_t words[$]);
		instr_pkg::dispatch_t beat;
		for (int i = 0; i < words.size(); i++) begin
			beat.instr = words[i];
			beat.id    = id;
			beat.last  = (i == words.size() - 1);
			expect_q.push_back(beat);
		end
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks and report
	task automatic check_beat(input instr_pkg::dispatch_t got, input instr_pkg::dispatch_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: got instr %h id %h last %b, want instr %h id %h last %b",
				$time, got.instr, got.id, got.last, exp.instr, exp.id, exp.last);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic finish_run();
		$display("Errors: %0d mismatches, %0d protocol errors, %0d timeouts",
			mismatches, protocol_errors, timeouts);
		if (mismatches + protocol_errors + timeouts == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	task automatic give_up(input string what);
		timeouts++;
		$display("Timeout at %0t while waiting for %s", $time, what);
		finish_run();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Host side, called on a falling edge and returns on one
	task automatic send_word(input instr_pkg::instr_t word, input string what,
		output logic waited);
		int cycles;
		cycles  = 0;
		waited  = 1'b0;
		st_word = word;
		#1;	// Take strobe settles after the new word
		while (!st_take) begin
			if (st_wait) waited = 1'b1;
			if (cycles == WAIT_LIMIT) give_up(what);
			@(negedge clock);
			cycles++;
		end
		if (st_wait) begin
			protocol_errors++;
			$display("st_take and st_wait both high at %0t", $time);
		end
		@(negedge clock);	// Taken on the rising edge in between
	endtask

	task automatic send_thread(input mpu_pkg::id_t id, input int len, output logic waited);
		instr_pkg::instr_t words[$];
		logic              dummy;
		for (int i = 0; i < len; i++) begin
			words.push_back(instr_pkg::instr_t'(next_random()));
		end
		model_thread(id, words);
		st_req = 1'b1;
		send_word(instr_pkg::instr_t'(len), "take of a length word", waited);
		send_word(instr_pkg::instr_t'(32'(id)), "take of an id word", dummy);
		foreach (words[i]) begin
			send_word(words[i], "take of an instruction word", dummy);
		end
	endtask

	task automatic host_idle();
		st_req  = 1'b0;
		st_word = '0;
	endtask

	// Every expected beat seen, then a few cycles for the retire
	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (expect_q.size() != 0) begin
			if (cycles == DRAIN_LIMIT) give_up("dispatch of the expected words");
			@(negedge clock);
			cycles++;
		end
		repeat (4) @(negedge clock);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Output compare
	always @(negedge clock) begin
		if (!reset && out_valid) begin
			if (expect_q.size() == 0) begin
				protocol_errors++;
				$display("Dispatch output at %0t with no word expected", $time);
			end else begin
				check_beat(out_data, expect_q.pop_front());
			end
		end
	end

	initial begin
		logic waited;
		int   len;
		int   cycles;
		st_req          = 1'b0;
		st_word         = '0;
		rng_state       = 32'd41;
		mismatches      = 0;
		protocol_errors = 0;
		timeouts        = 0;
		cycles          = 0;
		while (reset !== 1'b0) begin
			if (cycles == WAIT_LIMIT) give_up("reset release");
			@(negedge clock);
			cycles++;
		end

		// Quiet after reset
		repeat (3) begin
			@(negedge clock);
			check_flag("st_take", st_take, 1'b0);
			check_flag("st_wait", st_wait, 1'b0);
			check_flag("out_valid", out_valid, 1'b0);
		end

		// Single short thread
		send_thread(mpu_pkg::id_t'(8'h11), 5, waited);
		host_idle();
		check_flag("st_wait on a thread that fits", waited, 1'b0);
		wait_drain();

		// Back to back, random lengths
		for (int t = 0; t < NUM_RANDOM; t++) begin
			len = 1 + int'(next_random() % MAX_RANDOM);
			send_thread(mpu_pkg::id_t'(32 + t), len, waited);
		end
		host_idle();
		wait_drain();

		// Second thread must wait for the first to retire, window wraps here
		send_thread(mpu_pkg::id_t'(8'h40), BIG_A, waited);
		check_flag("st_wait on the first large thread", waited, 1'b0);
		send_thread(mpu_pkg::id_t'(8'h41), BIG_B, waited);
		check_flag("st_wait on the overflowing thread", waited, 1'b1);
		host_idle();
		wait_drain();
		check_flag("st_wait when idle", st_wait, 1'b0);

		finish_run();
	end

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 2
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD_NS / 2) clock = ~clock;
	end

	// Held over RESET_CYCLES rising edges, dropped on a falling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: hdl/mpu_top.sv
// MPU thread memory subsystem
`timescale 1ns/1ps
`default_nettype none

module mpu_top (
	input  wire logic                 clock,
	input  wire logic                 reset,
	input  wire logic                 st_req,
	input  wire instr_pkg::instr_t    st_word,
	output logic                      st_take,
	output logic                      st_wait,
	output logic                      out_valid,
	output instr_pkg::dispatch_t      out_data
);

	// Admission
	logic                    req_st;
	mpu_pkg::store_req_t     store_req;
	logic                    ack_st;
	mpu_pkg::mpu_address_t   used_size;
	// Thread entries
	logic                    entry_valid;
	mpu_pkg::thread_entry_t  entry;
	logic                    entry_pop;
	// Load port
	logic                    ld_req;
	mpu_pkg::mpu_address_t   ld_addr;
	instr_pkg::instr_t       ld_instr;
	// Retire
	logic                    retire_valid;
	mpu_pkg::retire_t        retire;

	thread_mem u_thread_mem (
		.clock       (clock),
		.reset       (reset),
		.st_req      (st_req),
		.st_word     (st_word),
		.st_take     (st_take),
		.st_wait     (st_wait),
		.req_st      (req_st),
		.store_req   (store_req),
		.ack_st      (ack_st),
		.used_size   (used_size),
		.entry_valid (entry_valid),
		.entry       (entry),
		.entry_pop   (entry_pop),
		.ld_req      (ld_req),
		.ld_addr     (ld_addr),
		.ld_instr    (ld_instr)
	);

	map_man u_map_man (
		.clock        (clock),
		.reset        (reset),
		.req_st       (req_st),
		.store_req    (store_req),
		.ack_st       (ack_st),
		.retire_valid (retire_valid),
		.retire       (retire),
		.used_size    (used_size)
	);

	dispatch_unit u_dispatch (
		.clock        (clock),
		.reset        (reset),
		.entry_valid  (entry_valid),
		.entry        (entry),
		.entry_pop    (entry_pop),
		.ld_req       (ld_req),
		.ld_addr      (ld_addr),
		.ld_instr     (ld_instr),
		.out_valid    (out_valid),
		.out_data     (out_data),
		.retire_valid (retire_valid),
		.retire       (retire)
	);

endmodule

`default_nettype wire

// File: hdl/dispatch_unit.sv
// Thread instruction dispatch
`timescale 1ns/1ps
`default_nettype none
`include "mpu_defines.svh"

module dispatch_unit (
	input  wire logic                    clock,
	input  wire logic                    reset,
	input  wire logic                    entry_valid,
	input  wire mpu_pkg::thread_entry_t  entry,
	output logic                         entry_pop,
	output logic                         ld_req,
	output mpu_pkg::mpu_address_t        ld_addr,
	input  wire instr_pkg::instr_t       ld_instr,
	output logic                         out_valid,
	output instr_pkg::dispatch_t         out_data,
	output logic                         retire_valid,
	output mpu_pkg::retire_t             retire
);

	localparam int WIDTH_ADDR = $clog2(`SIZE_THREAD_MEM);

	logic                   busy;		// Loads of a thread in progress
	logic [WIDTH_ADDR-1:0]  cur_addr;
	mpu_pkg::mpu_address_t  remain;
	mpu_pkg::mpu_address_t  cur_len;
	mpu_pkg::id_t           cur_id;
	logic                   issue_last;
	// Alongside the load latency
	logic                   p_valid;
	logic                   p_last;
	mpu_pkg::id_t           p_id;
	mpu_pkg::mpu_address_t  p_len;

	assign entry_pop  = entry_valid & ~busy;
	assign ld_req     = busy;
	assign ld_addr    = {1'b0, cur_addr};
	assign issue_last = busy & (remain == mpu_pkg::mpu_address_t'(1));

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
		end else if (entry_pop) begin
			busy <= 1'b1;
		end else if (issue_last) begin
			busy <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (entry_pop) begin
			cur_addr <= entry.base[WIDTH_ADDR-1:0];
			remain   <= entry.length;
			cur_len  <= entry.length;
			cur_id   <= entry.id;
		end else if (busy) begin
			cur_addr <= cur_addr + 1'b1;	// Window wrap
			remain   <= remain - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			p_valid <= 1'b0;
		end else begin
			p_valid <= busy;
		end
	end

	always_ff @(posedge clock) begin
		if (busy) begin
			p_id   <= cur_id;
			p_last <= issue_last;
			p_len  <= cur_len;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Output and retire, one cycle after each load
	assign out_valid    = p_valid;
	assign out_data     = '{instr: ld_instr, id: p_id, last: p_last};
	assign retire_valid = p_valid & p_last;
	assign retire       = '{id: p_id, length: p_len};

endmodule

`default_nettype wire

// File: hdl/map_man.sv
// Window space accounting
`timescale 1ns/1ps
`default_nettype none
`include "mpu_defines.svh"

module map_man (
	input  wire logic                   clock,
	input  wire logic                   reset,
	input  wire logic                   req_st,
	input  wire mpu_pkg::store_req_t    store_req,
	output logic                        ack_st,
	input  wire logic                   retire_valid,
	input  wire mpu_pkg::retire_t       retire,
	output mpu_pkg::mpu_address_t       used_size
);

	logic                   retire_pending;
	logic                   retire_pop;
	mpu_pkg::retire_t       retire_head;
	mpu_pkg::mpu_address_t  add_len;
	mpu_pkg::mpu_address_t  sub_len;

	// One pulse per request, request drops after the ack
	always_ff @(posedge clock) begin
		if (reset) begin
			ack_st <= 1'b0;
		end else begin
			ack_st <= req_st & ~ack_st;
		end
	end

	// Retires step aside on ack cycles
	assign retire_pop = retire_pending & ~ack_st;

	assign add_len = ack_st ? store_req.length : '0;
	assign sub_len = retire_pop ? retire_head.length : '0;

	always_ff @(posedge clock) begin
		if (reset) begin
			used_size <= '0;
		end else begin
			used_size <= used_size + add_len - sub_len;
		end
	end

	info_queue #(
		.payload_t (mpu_pkg::retire_t),
		.DEPTH     (`NUM_THREAD_ENTRY)
	) u_retire_queue (
		.clock     (clock),
		.reset     (reset),
		.push      (retire_valid),
		.push_data (retire),
		.pop       (retire_pop),
		.head      (retire_head),
		.valid     (retire_pending),
		.full      ()
	);

	// Admission in thread_mem keeps the window from overfilling
	a_used_bound: assert property (@(posedge clock) disable iff (reset)
		used_size <= `SIZE_THREAD_MEM)
		else $error("used_size above window size");

endmodule

`default_nettype wire

// File: hdl/thread_mem.sv
// Thread store and instruction memory
`timescale 1ns/1ps
`default_nettype none
`include "mpu_defines.svh"

module thread_mem (
	input  wire logic                   clock,
	input  wire logic                   reset,
	// Host side
	input  wire logic                   st_req,
	input  wire instr_pkg::instr_t      st_word,
	output logic                        st_take,
	output logic                        st_wait,
	// Map manager
	output logic                        req_st,
	output mpu_pkg::store_req_t         store_req,
	input  wire logic                   ack_st,
	input  wire mpu_pkg::mpu_address_t  used_size,
	// Thread entries to dispatch
	output logic                        entry_valid,
	output mpu_pkg::thread_entry_t      entry,
	input  wire logic                   entry_pop,
	// Load port
	input  wire logic                   ld_req,
	input  wire mpu_pkg::mpu_address_t  ld_addr,
	output instr_pkg::instr_t           ld_instr
);

	localparam int WIDTH_ADDR = $clog2(`SIZE_THREAD_MEM);
	localparam int WIDTH_LEN  = $bits(mpu_pkg::mpu_address_t);

	mpu_pkg::fsm_threadmem_t  state;
	mpu_pkg::mpu_address_t    len_in;		// Length field of the host word
	logic [WIDTH_LEN:0]       need_size;	// Room for the carry
	logic                     error_size;
	mpu_pkg::mpu_address_t    length_st;
	mpu_pkg::mpu_address_t    remain;		// Words still to store
	mpu_pkg::id_t             id_st;
	logic [WIDTH_ADDR-1:0]    wptr;
	logic [WIDTH_ADDR-1:0]    base_st;
	logic                     store;
	logic                     last_word;
	logic                     queue_full;
	mpu_pkg::thread_entry_t   entry_in;
	instr_pkg::instr_t        instr_mem [`SIZE_THREAD_MEM];

	assign len_in    = st_word[WIDTH_LEN-1:0];
	assign need_size = {1'b0, used_size} + {1'b0, len_in};

	////////////////////////////////////////////////////////////////////////////
	// Host handshake
	assign st_wait = error_size;
	assign st_take = st_req & (((state == mpu_pkg::CHECK) & ~error_size) |
		(state == mpu_pkg::RCVID) | (state == mpu_pkg::STORE));

	assign store     = st_req & (state == mpu_pkg::STORE);
	assign last_word = store & (remain == mpu_pkg::mpu_address_t'(1));

	// Held back while the entry queue has no room
	assign req_st    = (state == mpu_pkg::LOOKUP) & ~queue_full;
	assign store_req = '{id: id_st, length: length_st};

	// Overflow check, also primed in INIT so CHECK never sees a stale result
	always_ff @(posedge clock) begin
		if (reset) begin
			error_size <= 1'b0;
		end else if ((state == mpu_pkg::INIT) || (state == mpu_pkg::CHECK)) begin
			error_size <= st_req & (need_size > `SIZE_THREAD_MEM);
		end
	end

	always_ff @(posedge clock) begin
		if (state == mpu_pkg::CHECK) begin
			length_st <= len_in;
			remain    <= len_in;
		end else if (store) begin
			remain    <= remain - 1'b1;
		end
		if (state == mpu_pkg::SETUP) begin
			base_st <= wptr;	// Thread starts at the current write pointer
		end
		if ((state == mpu_pkg::RCVID) && st_req) begin
			id_st <= st_word[`WIDTH_ID-1:0];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= mpu_pkg::INIT;
		end else begin
			case (state)
				mpu_pkg::INIT:   if (st_req) state <= mpu_pkg::CHECK;
				mpu_pkg::CHECK:  if (st_req && !error_size) state <= mpu_pkg::SETUP;
				mpu_pkg::SETUP:  state <= mpu_pkg::RCVID;
				mpu_pkg::RCVID:  if (st_req) state <= mpu_pkg::LOOKUP;
				mpu_pkg::LOOKUP: if (ack_st) state <= mpu_pkg::STORE;
				mpu_pkg::STORE:  if (last_word) state <= mpu_pkg::INIT;
				default:         state <= mpu_pkg::INIT;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Instruction window
	always_ff @(posedge clock) begin
		if (reset) begin
			wptr <= '0;
		end else if (store) begin
			wptr <= wptr + 1'b1;	// Wraps modulo the window size
		end
	end

	always_ff @(posedge clock) begin
		if (store) begin
			instr_mem[wptr] <= st_word;
		end
		if (ld_req) begin
			ld_instr <= instr_mem[ld_addr[WIDTH_ADDR-1:0]];
		end
	end

	assign entry_in = '{id: id_st, base: {1'b0, base_st}, length: length_st};

	info_queue #(
		.payload_t (mpu_pkg::thread_entry_t),
		.DEPTH     (`NUM_THREAD_ENTRY)
	) u_entry_queue (
		.clock     (clock),
		.reset     (reset),
		.push      (last_word),
		.push_data (entry_in),
		.pop       (entry_pop),
		.head      (entry),
		.valid     (entry_valid),
		.full      (queue_full)
	);

	// Map manager only answers an open admission request
	a_ack_in_lookup: assert property (@(posedge clock) disable iff (reset)
		ack_st |-> (state == mpu_pkg::LOOKUP))
		else $error("ack_st outside LOOKUP");

endmodule

`default_nettype wire

// File: hdl/info_queue.sv
// Small payload queue
`timescale 1ns/1ps
`default_nettype none

module info_queue #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4,
	localparam int WIDTH_INDEX = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
	input  wire logic      clock,
	input  wire logic      reset,
	input  wire logic      push,
	input  wire payload_t  push_data,
	input  wire logic      pop,
	output payload_t       head,
	output logic           valid,
	output logic           full
);

	logic [WIDTH_INDEX-1:0] waddr;
	logic [WIDTH_INDEX-1:0] raddr;
	logic                   empty;
	payload_t               mem [DEPTH];

	assign valid = ~empty;
	assign head  = mem[raddr];	// Head shows without a read cycle

	always_ff @(posedge clock) begin
		if (push) begin
			mem[waddr] <= push_data;
		end
	end

	ring_buff_ctrl #(
		.NUM_ENTRY (DEPTH)
	) u_ctrl (
		.clock (clock),
		.reset (reset),
		.we    (push),
		.re    (pop),
		.waddr (waddr),
		.raddr (raddr),
		.full  (full),
		.empty (empty)
	);

endmodule

`default_nettype wire

// File: hdl/ring_buff_ctrl.sv
// Circular buffer pointer control
`timescale 1ns/1ps
`default_nettype none

module ring_buff_ctrl #(
	parameter int NUM_ENTRY = 4,
	localparam int WIDTH_INDEX = (NUM_ENTRY > 1) ? $clog2(NUM_ENTRY) : 1
) (
	input  wire logic                   clock,
	input  wire logic                   reset,
	input  wire logic                   we,
	input  wire logic                   re,
	output logic [WIDTH_INDEX-1:0]      waddr,
	output logic [WIDTH_INDEX-1:0]      raddr,
	output logic                        full,
	output logic                        empty
);

	logic [WIDTH_INDEX:0] count;	// Entries held

	assign full  = (count == NUM_ENTRY);
	assign empty = (count == '0);

	// Write pointer, wraps at NUM_ENTRY
	always_ff @(posedge clock) begin
		if (reset) begin
			waddr <= '0;
		end else if (we) begin
			waddr <= (waddr == WIDTH_INDEX'(NUM_ENTRY - 1)) ? '0 : waddr + 1'b1;
		end
	end

	// Read pointer
	always_ff @(posedge clock) begin
		if (reset) begin
			raddr <= '0;
		end else if (re) begin
			raddr <= (raddr == WIDTH_INDEX'(NUM_ENTRY - 1)) ? '0 : raddr + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else begin
			case ({we, re})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// Both or neither
			endcase
		end
	end

	a_no_overrun: assert property (@(posedge clock) disable iff (reset)
		!(we && full) && !(re && empty))
		else $error("ring buffer written while full or read while empty");

endmodule

`default_nettype wire

// File: hdl/instr_pkg.sv
// Instruction word formats
`default_nettype none
`include "mpu_defines.svh"

package instr_pkg;

	// Four equal fields per word
	localparam int WIDTH_FIELD = `WIDTH_INSTR / 4;

	// Length and id words reuse this layout, value in the low bits
	typedef struct packed {
		logic [WIDTH_FIELD-1:0] opcode;
		logic [WIDTH_FIELD-1:0] dst;
		logic [WIDTH_FIELD-1:0] src_a;
		logic [WIDTH_FIELD-1:0] src_b;
	} instr_t;

	// Dispatch output beat
	typedef struct packed {
		instr_t       instr;
		mpu_pkg::id_t id;
		logic         last;	// Final word of the thread
	} dispatch_t;

endpackage

`default_nettype wire

// File: hdl/mpu_pkg.sv
// MPU thread management types
`default_nettype none
`include "mpu_defines.svh"

package mpu_pkg;

	typedef logic [`WIDTH_ID-1:0] id_t;

	// One extra bit so a full window length fits
	typedef logic [$clog2(`SIZE_THREAD_MEM):0] mpu_address_t;

	////////////////////////////////////////////////////////////////////////////
	// Store FSM
	typedef enum logic [2:0] {
		INIT,	// Idle, waiting for a host request
		CHECK,	// Length word against free window space
		SETUP,
		RCVID,	// Identifier word
		LOOKUP,	// Admission by the map manager
		STORE	// Instruction words
	} fsm_threadmem_t;

	////////////////////////////////////////////////////////////////////////////
	// Between the management blocks

	// Admission request to the map manager
	typedef struct packed {
		id_t          id;
		mpu_address_t length;
	} store_req_t;

	// Stored thread, queued for dispatch
	typedef struct packed {
		id_t          id;
		mpu_address_t base;
		mpu_address_t length;
	} thread_entry_t;

	// Space handed back after dispatch
	typedef struct packed {
		id_t          id;
		mpu_address_t length;
	} retire_t;

endpackage

`default_nettype wire

// File: hdl/mpu_defines.svh
// MPU sizing macros
`ifndef MPU_DEFINES_SVH
`define MPU_DEFINES_SVH

// Instruction window depth in words
`define SIZE_THREAD_MEM 256

// Depth of the thread entry queue
`define NUM_THREAD_ENTRY 4

// Host and instruction bus width
`define WIDTH_INSTR 32

// Thread identifier width
`define WIDTH_ID 8

`endif
